/* Bender.yml */
package:
  name: exu

sources:
  - src/exu_pkg.sv
  - src/exu_operand_sel.sv
  - src/exu_alu.sv
  - src/exu_csr_exec.sv
  - src/exu_branch_resolve.sv
  - src/exu_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_exu.sv

/* flist.f */
+incdir+verif
src/exu_pkg.sv
src/exu_operand_sel.sv
src/exu_alu.sv
src/exu_csr_exec.sv
src/exu_branch_resolve.sv
src/exu_top.sv
verif/tb_exu.sv

/* src/exu_alu.sv */
`timescale 1ns/10ps

module exu_alu
  import exu_pkg::*;
(
  input  alu_op_e         alu_op_i,
  input  br_cond_e        br_cond_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_true_o
);

  logic [SHAMT_W-1:0] shamt;
  logic               eq;
  logic               lt_s;
  logic               lt_u;

  assign shamt = b_i[SHAMT_W-1:0];

  // shared by slt/sltu and the branch compare
  assign eq   = (a_i == b_i);
  assign lt_s = ($signed(a_i) < $signed(b_i));
  assign lt_u = (a_i < b_i);

  always_comb begin
    unique case (alu_op_i)
      ALU_ADD: begin
        result_o = a_i + b_i;
      end
      ALU_SUB: begin
        result_o = a_i - b_i;
      end
      ALU_SLL: begin
        result_o = a_i << shamt;
      end
      ALU_SLT: begin
        result_o = {{(XLEN-1){1'b0}}, lt_s};
      end
      ALU_SLTU: begin
        result_o = {{(XLEN-1){1'b0}}, lt_u};
      end
      ALU_XOR: begin
        result_o = a_i ^ b_i;
      end
      ALU_SRL: begin
        result_o = a_i >> shamt;
      end
      ALU_SRA: begin
        result_o = $signed(a_i) >>> shamt;  // sign fill
      end
      ALU_OR: begin
        result_o = a_i | b_i;
      end
      ALU_AND: begin
        result_o = a_i & b_i;
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

  // branch condition, evaluated whatever the alu op is
  always_comb begin
    unique case (br_cond_i)
      BR_BEQ:  cmp_true_o = eq;
      BR_BNE:  cmp_true_o = ~eq;
      BR_BLT:  cmp_true_o = lt_s;
      BR_BGE:  cmp_true_o = ~lt_s;
      BR_BLTU: cmp_true_o = lt_u;
      BR_BGEU: cmp_true_o = ~lt_u;
      default: cmp_true_o = 1'b0;
    endcase
  end

endmodule

/* src/exu_branch_resolve.sv */
`timescale 1ns/10ps

module exu_branch_resolve
  import exu_pkg::*;
(
  input  exc_op_e         exc_op_i,
  input  logic            cmp_true_i,
  input  logic            pred_taken_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] imm_i,
  output logic            is_branch_o,
  output logic            taken_o,
  output logic            pdt_correct_o,
  output logic            redirect_valid_o,
  output logic [XLEN-1:0] redirect_pc_o,
  output jump_type_e      jump_type_o
);

  logic            is_jal;
  logic            is_jalr;
  logic            is_br;
  logic            fall_through;
  logic [XLEN-1:0] target_base;
  logic [XLEN-1:0] target_off;

  assign is_jal  = (exc_op_i == EXC_JAL);
  assign is_jalr = (exc_op_i == EXC_JALR);
  assign is_br   = (exc_op_i == EXC_BRANCH);

  assign is_branch_o = is_br | is_jal | is_jalr;
  assign taken_o     = is_jal | is_jalr | (is_br & cmp_true_i);

  // mispredict in either direction redirects fetch
  assign pdt_correct_o    = (taken_o == pred_taken_i);
  assign redirect_valid_o = (taken_o != pred_taken_i);

  // predicted taken but not taken, go back to pc+4
  assign fall_through = pred_taken_i & ~taken_o;

  always_comb begin
    if (fall_through) begin
      target_base = pc_i;
      target_off  = XLEN'(INST_BYTES);
    end else begin
      target_base = is_jalr ? rs1_data_i : pc_i;  // jalr is register relative
      target_off  = imm_i;
    end
  end

  assign redirect_pc_o = target_base + target_off;

  always_comb begin
    if (is_jal) begin
      jump_type_o = JMP_JAL;
    end else if (is_jalr) begin
      jump_type_o = JMP_JALR;
    end else if (is_br) begin
      jump_type_o = JMP_BRANCH;
    end else begin
      jump_type_o = JMP_NONE;
    end
  end

endmodule

/* src/exu_csr_exec.sv */
`timescale 1ns/10ps

module exu_csr_exec
  import exu_pkg::*;
(
  input  csr_op_e              csr_op_i,
  input  logic                 csr_imm_valid_i,
  input  logic [CSR_IMM_W-1:0] csr_imm_i,
  input  logic [XLEN-1:0]      rs1_data_i,
  input  logic [XLEN-1:0]      csr_rdata_i,
  output logic [XLEN-1:0]      csr_wdata_o,
  output logic                 csr_we_o
);

  logic [XLEN-1:0] src;

  // csrr*i forms use the zero extended zimm
  assign src = csr_imm_valid_i ? {{(XLEN-CSR_IMM_W){1'b0}}, csr_imm_i} : rs1_data_i;

  always_comb begin
    unique case (csr_op_i)
      CSR_RW: begin
        csr_wdata_o = src;
      end
      CSR_RS: begin
        csr_wdata_o = csr_rdata_i | src;   // set bits
      end
      CSR_RC: begin
        csr_wdata_o = csr_rdata_i & ~src;  // clear bits
      end
      default: begin
        csr_wdata_o = csr_rdata_i;
      end
    endcase
  end

  // any real csr op writes back, even with a zero source
  assign csr_we_o = (csr_op_i != CSR_NONE);

endmodule

/* src/exu_operand_sel.sv */
`timescale 1ns/10ps

module exu_operand_sel
  import exu_pkg::*;
(
  input  exc_op_e         exc_op_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] csr_rdata_i,
  output logic [XLEN-1:0] alu_a_o,
  output logic [XLEN-1:0] alu_b_o
);

  logic [XLEN-1:0] upper_imm;

  // lui/auipc take imm[31:12] with the low bits cleared
  assign upper_imm = {imm_i[XLEN-1:UIMM_LSB], {UIMM_LSB{1'b0}}};

  always_comb begin
    alu_a_o = '0;
    alu_b_o = '0;
    unique case (exc_op_i)
      EXC_OPREG, EXC_BRANCH: begin
        alu_a_o = rs1_data_i;
        alu_b_o = rs2_data_i;
      end
      EXC_OPIMM, EXC_LOAD, EXC_STORE: begin
        alu_a_o = rs1_data_i;
        alu_b_o = imm_i;        // address or immediate operand
      end
      EXC_JAL, EXC_JALR: begin
        // link value pc+4 goes to rd
        alu_a_o = pc_i;
        alu_b_o = XLEN'(INST_BYTES);
      end
      EXC_AUIPC: begin
        alu_a_o = pc_i;
        alu_b_o = upper_imm;
      end
      EXC_LUI: begin
        alu_a_o = '0;
        alu_b_o = upper_imm;
      end
      EXC_CSR: begin
        alu_a_o = '0;
        alu_b_o = csr_rdata_i;  // old csr value passes to rd
      end
      default: begin
        alu_a_o = '0;
        alu_b_o = '0;
      end
    endcase
  end

endmodule

/* src/exu_pkg.sv */
package exu_pkg;

  localparam int XLEN       = 32;
  localparam int REG_AW     = 5;
  localparam int CSR_AW     = 12;
  localparam int SHAMT_W    = 5;   // rv32 shift amount
  localparam int CSR_IMM_W  = 5;   // zimm field of csrr*i
  localparam int UIMM_LSB   = 12;  // lui/auipc immediate starts here
  localparam int INST_BYTES = 4;   // link and fall-through step

  // instruction class from decode
  typedef enum logic [3:0] {
    EXC_NONE   = 4'd0,
    EXC_LUI    = 4'd1,
    EXC_AUIPC  = 4'd2,
    EXC_JAL    = 4'd3,
    EXC_JALR   = 4'd4,
    EXC_BRANCH = 4'd5,
    EXC_LOAD   = 4'd6,
    EXC_STORE  = 4'd7,
    EXC_OPIMM  = 4'd8,
    EXC_OPREG  = 4'd9,
    EXC_CSR    = 4'd10
  } exc_op_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_BEQ  = 3'd0,
    BR_BNE  = 3'd1,
    BR_BLT  = 3'd2,
    BR_BGE  = 3'd3,
    BR_BLTU = 3'd4,
    BR_BGEU = 3'd5
  } br_cond_e;

  typedef enum logic [1:0] {
    CSR_NONE = 2'd0,
    CSR_RW   = 2'd1,
    CSR_RS   = 2'd2,
    CSR_RC   = 2'd3
  } csr_op_e;

  // same code points the bpu side expects
  typedef enum logic [1:0] {
    JMP_NONE   = 2'b00,
    JMP_JAL    = 2'b01,
    JMP_JALR   = 2'b10,
    JMP_BRANCH = 2'b11
  } jump_type_e;

  typedef struct packed {
    logic [XLEN-1:0]      pc;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      csr_rdata;   // old csr value, read in decode
    logic [REG_AW-1:0]    rd_idx;
    logic [CSR_AW-1:0]    csr_addr;
    logic [CSR_IMM_W-1:0] csr_imm;
    logic                 csr_imm_valid;
    exc_op_e              exc_op;
    alu_op_e              alu_op;
    br_cond_e             br_cond;
    csr_op_e              csr_op;
    logic                 pred_taken;  // direction guessed at fetch
  } exu_issue_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   alu_result;
    logic [REG_AW-1:0] rd_idx;
    logic              csr_we;
    logic [CSR_AW-1:0] csr_addr;
    logic [XLEN-1:0]   csr_wdata;
    logic              is_branch;
    logic              branch_taken;
    logic              pdt_correct;
    logic              redirect_valid;
    logic [XLEN-1:0]   redirect_pc;
    jump_type_e        jump_type;
  } exu_result_t;

endpackage

/* src/exu_top.sv */
`timescale 1ns/10ps

module exu_top
  import exu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        req_i,
  input  exu_issue_t  issue_i,
  output logic        ack_o,
  output exu_result_t result_o
);

  typedef enum logic [1:0] {
    S_IDLE = 2'd0,
    S_BUSY = 2'd1,
    S_ACK  = 2'd2
  } state_e;

  state_e      state_q;
  logic        ack_q;
  exu_issue_t  issue_q;
  exu_result_t result_q;
  exu_result_t result_d;
  logic        capture;

  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_result;
  logic            cmp_true;
  logic [XLEN-1:0] csr_wdata;
  logic            csr_we;
  logic            is_branch;
  logic            taken;
  logic            pdt_correct;
  logic            redirect_valid;
  logic [XLEN-1:0] redirect_pc;
  jump_type_e      jump_type;

  assign capture = (state_q == S_IDLE) & req_i;

  // four-phase control, one packet in flight
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= S_IDLE;
      ack_q    <= 1'b0;
      result_q <= '0;
    end else begin
      unique case (state_q)
        S_IDLE: begin
          if (req_i) state_q <= S_BUSY;
        end
        S_BUSY: begin
          result_q <= result_d;  // blocks settled from issue_q
          ack_q    <= 1'b1;
          state_q  <= S_ACK;
        end
        S_ACK: begin
          if (!req_i) begin    // hold result until req drops
            ack_q   <= 1'b0;
            state_q <= S_IDLE;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (capture) issue_q <= issue_i;
  end

  exu_operand_sel u_operand_sel (
    .exc_op_i    (issue_q.exc_op),
    .pc_i        (issue_q.pc),
    .rs1_data_i  (issue_q.rs1_data),
    .rs2_data_i  (issue_q.rs2_data),
    .imm_i       (issue_q.imm),
    .csr_rdata_i (issue_q.csr_rdata),
    .alu_a_o     (alu_a),
    .alu_b_o     (alu_b)
  );

  exu_alu u_alu (
    .alu_op_i   (issue_q.alu_op),
    .br_cond_i  (issue_q.br_cond),
    .a_i        (alu_a),
    .b_i        (alu_b),
    .result_o   (alu_result),
    .cmp_true_o (cmp_true)
  );

  exu_csr_exec u_csr_exec (
    .csr_op_i        (issue_q.csr_op),
    .csr_imm_valid_i (issue_q.csr_imm_valid),
    .csr_imm_i       (issue_q.csr_imm),
    .rs1_data_i      (issue_q.rs1_data),
    .csr_rdata_i     (issue_q.csr_rdata),
    .csr_wdata_o     (csr_wdata),
    .csr_we_o        (csr_we)
  );

  exu_branch_resolve u_branch_resolve (
    .exc_op_i         (issue_q.exc_op),
    .cmp_true_i       (cmp_true),
    .pred_taken_i     (issue_q.pred_taken),
    .pc_i             (issue_q.pc),
    .rs1_data_i       (issue_q.rs1_data),
    .imm_i            (issue_q.imm),
    .is_branch_o      (is_branch),
    .taken_o          (taken),
    .pdt_correct_o    (pdt_correct),
    .redirect_valid_o (redirect_valid),
    .redirect_pc_o    (redirect_pc),
    .jump_type_o      (jump_type)
  );

  always_comb begin
    result_d                = '0;
    result_d.pc             = issue_q.pc;
    result_d.alu_result     = alu_result;
    result_d.rd_idx         = issue_q.rd_idx;
    result_d.csr_we         = csr_we;
    result_d.csr_addr       = issue_q.csr_addr;
    result_d.csr_wdata      = csr_wdata;
    result_d.is_branch      = is_branch;
    result_d.branch_taken   = taken;
    result_d.pdt_correct    = pdt_correct;
    result_d.redirect_valid = redirect_valid;
    result_d.redirect_pc    = redirect_pc;
    result_d.jump_type      = jump_type;
  end

  assign ack_o    = ack_q;
  assign result_o = result_q;

endmodule

/* verif/exu_ref_model.svh */
`ifndef EXU_REF_MODEL_SVH
`define EXU_REF_MODEL_SVH

// alu operand a by instruction class
function automatic logic [XLEN-1:0] operand_a(exu_issue_t p);
  case (p.exc_op)
    EXC_OPREG, EXC_OPIMM, EXC_LOAD, EXC_STORE, EXC_BRANCH: return p.rs1_data;
    EXC_JAL, EXC_JALR, EXC_AUIPC: return p.pc;
    default: return '0;  // lui, csr, none
  endcase
endfunction

function automatic logic [XLEN-1:0] operand_b(exu_issue_t p);
  case (p.exc_op)
    EXC_OPREG, EXC_BRANCH: return p.rs2_data;
    EXC_OPIMM, EXC_LOAD, EXC_STORE: return p.imm;
    EXC_JAL, EXC_JALR: return 32'd4;
    EXC_LUI, EXC_AUIPC: return p.imm & 32'hffff_f000;
    EXC_CSR: return p.csr_rdata;
    default: return '0;
  endcase
endfunction

// signed order by flipping the sign bits
function automatic logic less_signed(logic [XLEN-1:0] a, logic [XLEN-1:0] b);
  return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
endfunction

function automatic logic [XLEN-1:0] alu_compute(alu_op_e op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
  logic [4:0]      sh;
  logic [XLEN-1:0] fill;
  sh   = b[4:0];
  fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;  // ones shifted in by sra
  case (op)
    ALU_ADD:  return a + b;
    ALU_SUB:  return a + ~b + 32'd1;
    ALU_SLL:  return a << sh;
    ALU_SLT:  return {31'd0, less_signed(a, b)};
    ALU_SLTU: return {31'd0, a < b};
    ALU_XOR:  return a ^ b;
    ALU_SRL:  return a >> sh;
    ALU_SRA:  return (a >> sh) | fill;
    ALU_OR:   return a | b;
    ALU_AND:  return a & b;
    default:  return '0;
  endcase
endfunction

function automatic logic branch_cond_holds(br_cond_e c, logic [XLEN-1:0] a,
                                           logic [XLEN-1:0] b);
  case (c)
    BR_BEQ:  return a == b;
    BR_BNE:  return a != b;
    BR_BLT:  return less_signed(a, b);
    BR_BGE:  return !less_signed(a, b);
    BR_BLTU: return a < b;
    BR_BGEU: return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic logic [XLEN-1:0] csr_new_value(exu_issue_t p);
  logic [XLEN-1:0] src;
  src = p.csr_imm_valid ? {27'd0, p.csr_imm} : p.rs1_data;
  case (p.csr_op)
    CSR_RW:  return src;
    CSR_RS:  return p.csr_rdata | src;
    CSR_RC:  return p.csr_rdata & ~src;
    default: return p.csr_rdata;  // no write, value unused
  endcase
endfunction

function automatic exu_result_t expected_result(exu_issue_t p);
  exu_result_t r;
  logic        is_jump;
  r            = '0;
  r.pc         = p.pc;
  r.rd_idx     = p.rd_idx;
  r.csr_addr   = p.csr_addr;
  r.alu_result = alu_compute(p.alu_op, operand_a(p), operand_b(p));
  r.csr_we     = (p.csr_op != CSR_NONE);
  r.csr_wdata  = csr_new_value(p);
  is_jump      = (p.exc_op == EXC_JAL) || (p.exc_op == EXC_JALR);
  r.is_branch  = is_jump || (p.exc_op == EXC_BRANCH);
  r.branch_taken = is_jump ||
                   ((p.exc_op == EXC_BRANCH) && branch_cond_holds(p.br_cond, p.rs1_data,
                                                                  p.rs2_data));
  r.pdt_correct    = (r.branch_taken == p.pred_taken);
  r.redirect_valid = !r.pdt_correct;
  if (p.pred_taken && !r.branch_taken) begin
    r.redirect_pc = p.pc + 32'd4;  // wrong taken guess, fall through
  end else if (p.exc_op == EXC_JALR) begin
    r.redirect_pc = p.rs1_data + p.imm;
  end else begin
    r.redirect_pc = p.pc + p.imm;
  end
  case (p.exc_op)
    EXC_JAL:    r.jump_type = JMP_JAL;
    EXC_JALR:   r.jump_type = JMP_JALR;
    EXC_BRANCH: r.jump_type = JMP_BRANCH;
    default:    r.jump_type = JMP_NONE;
  endcase
  return r;
endfunction

`endif

/* verif/tb_exu.sv */
`timescale 1ns/10ps

module tb_exu
  import exu_pkg::*;
();

  localparam int NUM_PACKETS  = 2000;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_WAIT     = 8;
  localparam int TIMEOUT_NS   = NUM_PACKETS * 12 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
  localparam logic [31:0] SEED = 32'h5964_dddf;

  logic        clk;
  logic        rst_n_i;
  logic        req_i;
  exu_issue_t  issue_i;
  logic        ack_o;
  exu_result_t result_o;
  int          errors = 0;
  int          checks = 0;

  `include "exu_ref_model.svh"

  exu_top dut (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .req_i    (req_i),
    .issue_i  (issue_i),
    .ack_o    (ack_o),
    .result_o (result_o)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic exu_issue_t random_issue();
    exu_issue_t p;
    p.pc            = $urandom & 32'hffff_fffc;  // word aligned
    p.rs1_data      = $urandom;
    p.rs2_data      = ($urandom_range(3) == 0) ? p.rs1_data : $urandom;  // hit equal compares
    p.imm           = $urandom;
    p.csr_rdata     = $urandom;
    p.rd_idx        = $urandom;
    p.csr_addr      = $urandom;
    p.csr_imm       = $urandom;
    p.csr_imm_valid = $urandom;
    p.exc_op        = exc_op_e'($urandom_range(10));
    p.alu_op        = ALU_ADD;
    if (p.exc_op == EXC_OPREG || p.exc_op == EXC_OPIMM) begin
      p.alu_op = alu_op_e'($urandom_range(9));
    end
    p.br_cond    = br_cond_e'($urandom_range(5));
    p.csr_op     = (p.exc_op == EXC_CSR) ? csr_op_e'($urandom_range(3)) : CSR_NONE;
    p.pred_taken = $urandom;
    return p;
  endfunction

  function automatic string alu_test_name(exc_op_e op);
    case (op)
      EXC_LUI, EXC_AUIPC, EXC_JAL, EXC_JALR: return "upper_and_link";
      EXC_CSR: return "csr_exec";
      default: return "alu_ops";
    endcase
  endfunction

  task automatic compare_word(input string test, input string field,
                              input logic [XLEN-1:0] exp_v, input logic [XLEN-1:0] act_v);
    checks++;
    assert (act_v === exp_v) else begin
      errors++;
      $display("ERROR %s: %s expected %h actual %h", test, field, exp_v, act_v);
    end
  endtask

  // counts edges until ack_o is seen at level on a falling edge
  task automatic wait_for_ack(input logic level, output int edges);
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (ack_o !== level && edges < MAX_WAIT);
  endtask

  task automatic check_result(input exu_issue_t p);
    exu_result_t exp;
    exp = expected_result(p);
    compare_word(alu_test_name(p.exc_op), "alu_result", exp.alu_result, result_o.alu_result);
    compare_word("handshake", "pc", exp.pc, result_o.pc);
    compare_word("handshake", "rd_idx", exp.rd_idx, result_o.rd_idx);
    compare_word("csr_exec", "csr_we", exp.csr_we, result_o.csr_we);
    compare_word("csr_exec", "csr_addr", exp.csr_addr, result_o.csr_addr);
    if (exp.csr_we) begin
      compare_word("csr_exec", "csr_wdata", exp.csr_wdata, result_o.csr_wdata);
    end
    compare_word("branch_resolve", "is_branch", exp.is_branch, result_o.is_branch);
    compare_word("branch_resolve", "branch_taken", exp.branch_taken, result_o.branch_taken);
    compare_word("branch_resolve", "pdt_correct", exp.pdt_correct, result_o.pdt_correct);
    compare_word("branch_resolve", "redirect_valid", exp.redirect_valid,
                 result_o.redirect_valid);
    if (exp.redirect_valid) begin  // target only matters on a redirect
      compare_word("branch_resolve", "redirect_pc", exp.redirect_pc, result_o.redirect_pc);
    end
    compare_word("branch_resolve", "jump_type", exp.jump_type, result_o.jump_type);
  endtask

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("watchdog: handshake hung, run stopped after %0d ns", TIMEOUT_NS);
    $display("Errors found");
    $finish;
  end

  initial begin : stimulus
    exu_issue_t  pkt;
    int          edges;
    int          hold;
    int          gap;
    req_i   = 1'b0;
    issue_i = '0;
    rst_n_i = 1'b0;
    void'($urandom(SEED));
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    checks++;
    assert (ack_o === 1'b0 && result_o === '0) else begin
      errors++;
      $display("ERROR handshake: reset state expected ack 0 result 0 actual ack %b result %h",
               ack_o, result_o);
    end
    for (int n = 0; n < NUM_PACKETS; n++) begin
      pkt = random_issue();
      @(posedge clk);
      issue_i <= pkt;
      req_i   <= 1'b1;
      wait_for_ack(1'b1, edges);
      compare_word("handshake", "edges to ack rise", 32'd2, edges);
      if (ack_o === 1'b1) begin
        check_result(pkt);
      end
      hold = ($urandom_range(3) == 0) ? $urandom_range(3, 1) : 0;  // back-pressure
      repeat (hold) begin
        @(posedge clk);
        issue_i <= random_issue();  // new packet offered while req stays high
        @(negedge clk);
        compare_word("handshake", "ack_o while req held", 32'd1, ack_o);
        check_result(pkt);
      end
      @(posedge clk);
      req_i <= 1'b0;
      wait_for_ack(1'b0, edges);
      compare_word("handshake", "edges to ack fall", 32'd1, edges);
      gap = $urandom_range(3);
      repeat (gap) @(posedge clk);
    end
    $display("tb_exu: %0d packets, %0d checks, %0d errors", NUM_PACKETS, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
